// File: verilog/fetch_pkg.sv
// fetch unit constants, RV32/RVC opcode values
// and the instruction word union with its two views
package fetch_pkg;

  localparam int axi_id_width = 4;
  localparam int line_bytes   = 8;  // one 64-bit line per AXI beat

  localparam logic [31:0] nop_instr = 32'h0000_0013;  // addi x0,x0,0
  localparam logic [31:1] reset_pc  = 31'h0000_0000;

  // RV32 major opcodes
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  // RVC quadrant 1 control transfers
  localparam logic [1:0] rvc_q1 = 2'b01;
  localparam logic [2:0] c_j    = 3'b101;
  localparam logic [2:0] c_beqz = 3'b110;
  localparam logic [2:0] c_bnez = 3'b111;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rv32;
    struct packed {
      struct packed {
        logic [2:0]  funct3;
        logic [10:0] payload;
        logic [1:0]  op;
      } hi;
      struct packed {
        logic [2:0]  funct3;
        logic [10:0] payload;  // bits 12:2 of the halfword
        logic [1:0]  op;
      } lo;
    } rvc;
  } instr_u;

endpackage : fetch_pkg

// File: verilog/fetch_predecode.sv
// early decode of one candidate instruction:
// length, branch and jump class, jump target, illegal halfword
`timescale 1ns/10ps

module fetch_predecode (
  input  fetch_pkg::instr_u instr_word,
  input  logic [31:1]       pc,
  output logic              is_comp,
  output logic              is_branch,
  output logic              is_jump,
  output logic [31:1]       target,
  output logic              is_illegal
);

  logic        c1_quad;
  logic [2:0]  c_funct3;
  logic [10:0] cp;
  logic [6:0]  opcode;
  logic [31:1] j_imm;
  logic [31:1] cj_imm;

  assign is_comp  = instr_word.rvc.lo.op != 2'b11;
  assign c1_quad  = instr_word.rvc.lo.op == fetch_pkg::rvc_q1;
  assign c_funct3 = instr_word.rvc.lo.funct3;
  assign cp       = instr_word.rvc.lo.payload;
  assign opcode   = instr_word.rv32.opcode;

  always_comb begin
    if (is_comp) begin
      is_branch = c1_quad && (c_funct3 == fetch_pkg::c_beqz || c_funct3 == fetch_pkg::c_bnez);
      is_jump   = c1_quad && (c_funct3 == fetch_pkg::c_j);
    end else begin
      is_branch = opcode == fetch_pkg::op_branch;
      is_jump   = opcode == fetch_pkg::op_jal;
    end
  end

  // J-type offset, imm[20|10:1|11|19:12] scattered over the rv32 fields
  assign j_imm = {{12{instr_word.rv32.funct7[6]}},
                  instr_word.rv32.rs1,
                  instr_word.rv32.funct3,
                  instr_word.rv32.rs2[0],
                  instr_word.rv32.funct7[5:0],
                  instr_word.rv32.rs2[4:1]};

  // CJ-type offset, imm[11|4|9:8|10|6|7|3:1|5] from halfword bits 12:2
  assign cj_imm = {{21{cp[10]}},
                   cp[6],
                   cp[8],
                   cp[7],
                   cp[4],
                   cp[5],
                   cp[0],
                   cp[9],
                   cp[3],
                   cp[2],
                   cp[1]};

  assign target = pc + (is_comp ? cj_imm : j_imm);  // halfword units

  assign is_illegal = instr_word.rvc.lo == 16'h0000;  // defined illegal encoding

endmodule : fetch_predecode

// File: verilog/fetch_axi_ctrl.sv
// AXI4 read master for 64-bit instruction lines
// one line buffer with bypass, epoch tagged ids to drop stale beats
`timescale 1ns/10ps

module fetch_axi_ctrl (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              fetch_req,
  input  logic [31:3]                       fetch_addr,
  input  logic                              redirect,
  input  logic                              line_consume,
  output logic                              line_valid,
  output logic [63:0]                       line_data,
  output logic                              line_err,
  // AR channel
  output logic [fetch_pkg::axi_id_width-1:0] arid,
  output logic [31:0]                       araddr,
  output logic [7:0]                        arlen,
  output logic [2:0]                        arsize,
  output logic [1:0]                        arburst,
  output logic                              arvalid,
  input  logic                              arready,
  // R channel
  input  logic [fetch_pkg::axi_id_width-1:0] rid,
  input  logic [63:0]                       rdata,
  input  logic [1:0]                        rresp,
  input  logic                              rlast,
  input  logic                              rvalid,
  output logic                              rready
);

  localparam int off_w = $clog2(fetch_pkg::line_bytes);

  logic [fetch_pkg::axi_id_width-1:0] epoch;
  logic [31:3]                        next_addr;
  logic [31:3]                        ar_line;
  logic [1:0]                         inflight;
  logic                               buf_valid;
  logic [63:0]                        buf_data;
  logic                               buf_err;
  logic                               ar_fire;
  logic                               issue;
  logic                               r_stale;
  logic                               beat_ok;
  logic                               r_fire;
  logic                               r_done;

  assign ar_fire = arvalid && arready;
  assign issue   = fetch_req && !arvalid && (inflight < 2'd2);  // at most two reads out

  // beats from an older epoch, or arriving during the redirect itself, are dropped
  assign r_stale = (rid != epoch) || redirect;
  assign beat_ok = rvalid && !r_stale;
  assign rready  = !buf_valid || r_stale;
  assign r_fire  = rvalid && rready;
  assign r_done  = r_fire && rlast;

  assign araddr  = {ar_line, {off_w{1'b0}}};
  assign arlen   = 8'd0;
  assign arsize  = 3'(off_w);
  assign arburst = 2'b01;  // INCR

  // an empty buffer passes the incoming beat straight through
  assign line_valid = buf_valid || beat_ok;
  assign line_data  = buf_valid ? buf_data : rdata;
  assign line_err   = buf_valid ? buf_err : (rresp != 2'b00);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      epoch     <= '0;
      next_addr <= fetch_pkg::reset_pc[31:3];
      ar_line   <= fetch_pkg::reset_pc[31:3];
      arid      <= '0;
      arvalid   <= 1'b0;
    end else begin
      if (ar_fire) arvalid <= 1'b0;
      if (issue) begin
        arvalid <= 1'b1;
        ar_line <= next_addr;
        arid    <= epoch;
      end
      if (redirect) begin
        epoch     <= epoch + 1'b1;
        next_addr <= fetch_addr;  // aligner already shows the new line
      end else if (issue) begin
        next_addr <= next_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight <= 2'd0;
    end else if (ar_fire && !r_done) begin
      inflight <= inflight + 2'd1;
    end else if (!ar_fire && r_done) begin
      inflight <= inflight - 2'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_valid <= 1'b0;
    end else if (redirect || (buf_valid && line_consume)) begin
      buf_valid <= 1'b0;
    end else if (!buf_valid && beat_ok && !line_consume) begin
      buf_valid <= 1'b1;  // bypassed line not finished this cycle
    end
  end

  always_ff @(posedge clk) begin
    if (!buf_valid && beat_ok) begin
      buf_data <= rdata;
      buf_err  <= rresp != 2'b00;
    end
  end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
    else $error("arvalid dropped or araddr changed before arready");

  consume_valid: assert property (@(posedge clk) disable iff (!rst_n)
    line_consume |-> line_valid)
    else $error("line consumed while no line is valid");

endmodule : fetch_axi_ctrl

// File: verilog/fetch_aligner.sv
// pc sequencer over the fetched line with straddle handling,
// jump redirect and the registered decode-stage outputs
`timescale 1ns/10ps

module fetch_aligner (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall,
  input  logic              pc_update,
  input  logic [31:1]       pc_in,
  input  logic              line_valid,
  input  logic [63:0]       line_data,
  input  logic              line_err,
  output logic              fetch_req,
  output logic [31:3]       fetch_addr,
  output logic              line_consume,
  output logic              redirect,
  output fetch_pkg::instr_u instr,
  output logic [31:1]       pc_out,
  output logic              comp,
  output logic              br,
  output logic              illegal,
  output logic              instr_valid
);

  logic [31:1]       pc;
  logic              have_hi;
  logic [15:0]       hi_half;
  logic              hi_err;
  logic              jmp_pend;
  logic [63:0]       shifted;
  fetch_pkg::instr_u cand;
  logic              cand_err;
  logic              is_comp;
  logic              is_branch;
  logic              is_jump;
  logic [31:1]       target;
  logic              is_illegal;
  logic              advance;
  logic              straddle;
  logic              emit;
  logic [2:0]        end_off;

  // a taken jump waits here until decode has taken the jump itself
  assign redirect   = pc_update || (jmp_pend && !stall);
  assign fetch_req  = !redirect && !jmp_pend;
  assign fetch_addr = pc_update ? pc_in[31:3] : pc[31:3];

  assign shifted  = line_data >> {pc[2:1], 4'b0000};
  assign cand     = have_hi ? {line_data[15:0], hi_half} : shifted[31:0];
  assign cand_err = line_err || (have_hi && hi_err);

  fetch_predecode predec (
    .instr_word(cand),
    .pc        (pc),
    .is_comp   (is_comp),
    .is_branch (is_branch),
    .is_jump   (is_jump),
    .target    (target),
    .is_illegal(is_illegal)
  );

  assign advance  = !stall && !pc_update && !jmp_pend && line_valid;
  assign straddle = advance && !have_hi && (pc[2:1] == 2'd3) && !is_comp;  // upper half next line
  assign emit     = advance && !straddle;
  assign end_off  = {1'b0, pc[2:1]} + (is_comp ? 3'd1 : 3'd2);

  // done with the line once the next pc leaves it; a jump leaves the flush to redirect
  assign line_consume = straddle || (emit && !is_jump && !have_hi && end_off[2]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc       <= fetch_pkg::reset_pc;
      have_hi  <= 1'b0;
      jmp_pend <= 1'b0;
    end else if (pc_update) begin
      pc       <= pc_in;
      have_hi  <= 1'b0;
      jmp_pend <= 1'b0;
    end else if (redirect) begin
      jmp_pend <= 1'b0;
    end else if (straddle) begin
      have_hi <= 1'b1;  // pc stays on the first half
    end else if (emit) begin
      have_hi <= 1'b0;
      if (is_jump) begin
        pc       <= target;
        jmp_pend <= 1'b1;
      end else begin
        pc <= pc + (is_comp ? 31'd1 : 31'd2);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (straddle) begin
      hi_half <= line_data[63:48];
      hi_err  <= line_err;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr       <= fetch_pkg::nop_instr;
      pc_out      <= fetch_pkg::reset_pc;
      comp        <= 1'b0;
      br          <= 1'b0;
      illegal     <= 1'b0;
      instr_valid <= 1'b0;
    end else if (pc_update || (!stall && !emit)) begin
      instr       <= fetch_pkg::nop_instr;  // bubble
      comp        <= 1'b0;
      br          <= 1'b0;
      illegal     <= 1'b0;
      instr_valid <= 1'b0;
    end else if (emit) begin
      if (is_comp) begin
        instr <= {16'h0000, cand.rvc.lo};
      end else begin
        instr <= cand;
      end
      pc_out      <= pc;
      comp        <= is_comp;
      br          <= is_branch;
      illegal     <= is_illegal || cand_err;
      instr_valid <= 1'b1;
    end
  end

  bubble_after_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    redirect |=> !instr_valid)
    else $error("instruction valid in the cycle after a redirect");

endmodule : fetch_aligner

// File: verilog/fetch_unit_top.sv
// instruction fetch front end top level
// AXI line controller and aligner
`timescale 1ns/10ps

module fetch_unit_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               stall,
  input  logic                               pc_update,
  input  logic [31:1]                        pc_in,
  output fetch_pkg::instr_u                  instr,
  output logic [31:1]                        pc_out,
  output logic                               comp,
  output logic                               br,
  output logic                               illegal,
  output logic                               instr_valid,
  // AR channel
  output logic [fetch_pkg::axi_id_width-1:0] arid,
  output logic [31:0]                        araddr,
  output logic [7:0]                         arlen,
  output logic [2:0]                         arsize,
  output logic [1:0]                         arburst,
  output logic                               arvalid,
  input  logic                               arready,
  // R channel
  input  logic [fetch_pkg::axi_id_width-1:0] rid,
  input  logic [63:0]                        rdata,
  input  logic [1:0]                         rresp,
  input  logic                               rlast,
  input  logic                               rvalid,
  output logic                               rready
);

  logic        fetch_req;
  logic [31:3] fetch_addr;
  logic        line_consume;
  logic        redirect;
  logic        line_valid;
  logic [63:0] line_data;
  logic        line_err;

  fetch_axi_ctrl ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .redirect    (redirect),
    .line_consume(line_consume),
    .line_valid  (line_valid),
    .line_data   (line_data),
    .line_err    (line_err),
    .arid        (arid),
    .araddr      (araddr),
    .arlen       (arlen),
    .arsize      (arsize),
    .arburst     (arburst),
    .arvalid     (arvalid),
    .arready     (arready),
    .rid         (rid),
    .rdata       (rdata),
    .rresp       (rresp),
    .rlast       (rlast),
    .rvalid      (rvalid),
    .rready      (rready)
  );

  fetch_aligner align (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .pc_update   (pc_update),
    .pc_in       (pc_in),
    .line_valid  (line_valid),
    .line_data   (line_data),
    .line_err    (line_err),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .line_consume(line_consume),
    .redirect    (redirect),
    .instr       (instr),
    .pc_out      (pc_out),
    .comp        (comp),
    .br          (br),
    .illegal     (illegal),
    .instr_valid (instr_valid)
  );

endmodule : fetch_unit_top

// File: sim/axi_mem_model.sv
// AXI4 read slave over a 64-bit line memory
// random arready, random response latency, in-order single-beat responses
`timescale 1ns/10ps

module axi_mem_model (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [fetch_pkg::axi_id_width-1:0] arid,
  input  logic [31:0]                        araddr,
  input  logic [7:0]                         arlen,
  input  logic [2:0]                         arsize,
  input  logic [1:0]                         arburst,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [fetch_pkg::axi_id_width-1:0] rid,
  output logic [63:0]                        rdata,
  output logic [1:0]                         rresp,
  output logic                               rlast,
  output logic                               rvalid,
  input  logic                               rready
);

  logic [63:0] lines [0:63];  // 512 bytes, written by the testbench

  logic [fetch_pkg::axi_id_width-1:0] q_id[$];
  logic [5:0]                         q_line[$];
  int                                 q_due[$];
  int                                 cycle;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rid     <= '0;
      rdata   <= '0;
      rresp   <= 2'b00;
      rlast   <= 1'b0;
      cycle   <= 0;
      q_id.delete();
      q_line.delete();
      q_due.delete();
    end else begin
      cycle   <= cycle + 1;
      arready <= ($urandom % 4) != 0;
      if (!(rvalid && !rready)) begin  // beat free to change
        if (q_id.size() > 0 && q_due[0] <= cycle) begin
          rid    <= q_id.pop_front();
          rdata  <= lines[q_line.pop_front()];
          void'(q_due.pop_front());
          rresp  <= 2'b00;
          rlast  <= 1'b1;
          rvalid <= 1'b1;
        end else begin
          rvalid <= 1'b0;
          rlast  <= 1'b0;
        end
      end
      if (arvalid && arready) begin
        q_id.push_back(arid);
        q_line.push_back(araddr[8:3]);
        q_due.push_back(cycle + 1 + int'($urandom % 6));
      end
    end
  end

endmodule : axi_mem_model

// File: sim/fetch_tb.sv
// fetch unit testbench: stimulus table of code images and expected
// instruction streams, compare tasks, cycle limit and final report
`timescale 1ns/10ps

module fetch_tb;

  localparam int n_cases = 6;
  localparam int max_lines = 8;
  localparam int max_ent = 12;

  typedef struct packed {
    fetch_pkg::instr_u instr;
    logic [31:1]       pc;
    logic              comp;
    logic              br;
    logic              ill;
  } exp_t;

  logic clk, rst_n, stall, pc_update;
  logic [31:1] pc_in;
  fetch_pkg::instr_u instr;
  logic [31:1] pc_out;
  logic comp, br, illegal, instr_valid;
  logic [fetch_pkg::axi_id_width-1:0] arid, rid;
  logic [31:0] araddr;
  logic [7:0] arlen;
  logic [2:0] arsize;
  logic [1:0] arburst, rresp;
  logic arvalid, arready, rlast, rvalid, rready;
  logic [63:0] rdata;

  string       case_name[n_cases];
  logic [63:0] img[n_cases][max_lines];
  int          img_base[n_cases];  // byte address of first line
  int          img_len[n_cases];
  logic [31:1] start_pc[n_cases];
  int          stall_pct[n_cases];
  int          upd_step[n_cases];  // -1 for no mid-stream pc_update
  logic [31:1] upd_pc[n_cases];
  exp_t        exp_tab[n_cases][max_ent];
  int          exp_n[n_cases];
  string       cur_name = "reset";
  int          mism_errs = 0;
  int          other_errs = 0;
  int          limit = 0;
  int          cycles = 0;

  fetch_unit_top DUT (.*);

  axi_mem_model mem (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (limit > 0) begin
      cycles++;
      if (cycles >= limit) begin
        $display("run did not finish within %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
      end
    end
  end

  // every read request is a single line aligned 8-byte INCR beat
  always @(negedge clk) begin
    if (rst_n && arvalid) begin
      check_ar(cur_name, araddr, arlen, arsize, arburst);
    end
  end

  task automatic setup_case(input int c, input string name, input int base, input logic [31:0] start,
                            input int pct, input int step, input logic [31:0] upd);
    case_name[c] = name;
    img_base[c]  = base;
    img_len[c]   = 0;
    start_pc[c]  = start[31:1];
    stall_pct[c] = pct;
    upd_step[c]  = step;
    upd_pc[c]    = upd[31:1];
    exp_n[c]     = 0;
  endtask

  task automatic add_line(input int c, input logic [63:0] data);
    img[c][img_len[c]] = data;
    img_len[c]++;
  endtask

  task automatic add_entry(input int c, input logic [31:0] word, input logic [31:0] byte_pc,
                           input bit e_comp, input bit e_br, input bit e_ill);
    exp_tab[c][exp_n[c]].instr = word;
    exp_tab[c][exp_n[c]].pc    = byte_pc[31:1];
    exp_tab[c][exp_n[c]].comp  = e_comp;
    exp_tab[c][exp_n[c]].br    = e_br;
    exp_tab[c][exp_n[c]].ill   = e_ill;
    exp_n[c]++;
  endtask

  task automatic check_instr(input string name, input fetch_pkg::instr_u e, input fetch_pkg::instr_u a);
    if (e !== a) begin
      $display("mismatch %s instr expected %h actual %h", name, e, a);
      mism_errs++;
    end
  endtask

  task automatic check_pc(input string name, input logic [31:1] e, input logic [31:1] a);
    if (e !== a) begin
      $display("mismatch %s pc expected %h actual %h", name, {e, 1'b0}, {a, 1'b0});
      mism_errs++;
    end
  endtask

  task automatic check_flag(input string name, input string what, input bit e, input bit a);
    if (e !== a) begin
      $display("mismatch %s %s expected %0b actual %0b", name, what, e, a);
      mism_errs++;
    end
  endtask

  task automatic check_ar(input string name, input logic [31:0] addr, input logic [7:0] len,
                          input logic [2:0] size, input logic [1:0] burst);
    logic [15:0] e;
    logic [15:0] a;
    e = {8'd0, 3'd3, 2'b01, 3'b000};  // arlen, arsize, arburst, byte offset
    a = {len, size, burst, addr[2:0]};
    if (e !== a) begin
      $display("mismatch %s ar len,size,burst,offset expected %h actual %h", name, e, a);
      mism_errs++;
    end
  endtask

  task automatic build_table();
    setup_case(0, "aligned32", 'h20, 'h20, 0, -1, 0);  // addi x1..x4, add x5
    add_line(0, 64'h00200113_00100093);
    add_line(0, 64'h00400213_00300193);
    add_line(0, 64'h00000013_002082b3);
    add_entry(0, 32'h00100093, 'h20, 0, 0, 0);
    add_entry(0, 32'h00200113, 'h24, 0, 0, 0);
    add_entry(0, 32'h00300193, 'h28, 0, 0, 0);
    add_entry(0, 32'h00400213, 'h2c, 0, 0, 0);
    add_entry(0, 32'h002082b3, 'h30, 0, 0, 0);
    for (int k = 0; k < 2; k++) begin  // same mixed code, second copy under random stall
      setup_case(1 + 3 * k, k ? "random_stall" : "mixed_straddle", 'h40 + 'hc0 * k,
                 'h40 + 'hc0 * k, k ? 50 : 0, -1, 0);
      add_line(1 + 3 * k, 64'h0113_0010_0093_0085);  // c.addi, addi, lower half of addi x2
      add_line(1 + 3 * k, 64'h0030_0193_4109_0020);
      add_line(1 + 3 * k, 64'h00000013_002082b3);
      add_entry(1 + 3 * k, 32'h00000085, 'h40 + 'hc0 * k, 1, 0, 0);
      add_entry(1 + 3 * k, 32'h00100093, 'h42 + 'hc0 * k, 0, 0, 0);
      add_entry(1 + 3 * k, 32'h00200113, 'h46 + 'hc0 * k, 0, 0, 0);
      add_entry(1 + 3 * k, 32'h00004109, 'h4a + 'hc0 * k, 1, 0, 0);
      add_entry(1 + 3 * k, 32'h00300193, 'h4c + 'hc0 * k, 0, 0, 0);
      add_entry(1 + 3 * k, 32'h002082b3, 'h50 + 'hc0 * k, 0, 0, 0);
    end
    setup_case(2, "jumps", 'h80, 'h80, 0, -1, 0);
    add_line(2, 64'h00c0006f_00208463);  // beq x1,x2,+8 then jal x0,+12
    add_line(2, 64'h00200113_00100093);  // skipped by the jal
    add_line(2, 64'hE091_0001_0001_A019);  // c.j +6, two c.nop skipped, c.bnez
    add_line(2, 64'h00400213_00300193);
    add_entry(2, 32'h00208463, 'h80, 0, 1, 0);
    add_entry(2, 32'h00c0006f, 'h84, 0, 0, 0);
    add_entry(2, 32'h0000a019, 'h90, 1, 0, 0);
    add_entry(2, 32'h0000e091, 'h96, 1, 1, 0);
    add_entry(2, 32'h00300193, 'h98, 0, 0, 0);
    add_entry(2, 32'h00400213, 'h9c, 0, 0, 0);
    setup_case(3, "pc_update_mid", 'hc0, 'hc0, 0, 2, 'he4);
    add_line(3, 64'h00200113_00100093);
    add_line(3, 64'h00400213_00300193);  // old path, must not appear
    add_line(3, 64'h00000013_00000013);
    add_line(3, 64'h00000013_00000013);
    add_line(3, 64'h002082b3_00000013);
    add_line(3, 64'h00200113_00100093);
    add_entry(3, 32'h00100093, 'hc0, 0, 0, 0);
    add_entry(3, 32'h00200113, 'hc4, 0, 0, 0);
    add_entry(3, 32'h002082b3, 'he4, 0, 0, 0);
    add_entry(3, 32'h00100093, 'he8, 0, 0, 0);
    add_entry(3, 32'h00200113, 'hec, 0, 0, 0);
    setup_case(5, "illegal_half", 'h140, 'h140, 0, -1, 0);
    add_line(5, 64'h0010_0093_0085_0000);
    add_line(5, 64'h00000013_00000013);
    add_entry(5, 32'h00000000, 'h140, 1, 0, 1);
    add_entry(5, 32'h00000085, 'h142, 1, 0, 0);
    add_entry(5, 32'h00100093, 'h144, 0, 0, 0);
  endtask

  task automatic run_case(input int c);
    int   got;
    int   waited;
    bit   upd_done;
    exp_t e;
    cur_name = case_name[c];
    for (int li = 0; li < 64; li++) begin
      mem.lines[li] = {~(32'(li * 8)), 32'(li * 8)};  // address-derived fill
    end
    for (int li = 0; li < img_len[c]; li++) begin
      mem.lines[img_base[c] / 8 + li] = img[c][li];
    end
    got = 0;
    waited = 0;
    upd_done = 0;
    @(posedge clk);
    #1;
    pc_update = 1'b1;
    pc_in = start_pc[c];
    stall = 1'b0;
    while (got < exp_n[c] && waited < exp_n[c] * 40) begin
      @(negedge clk);
      if (!pc_update && instr_valid && !stall) begin  // taken by decode at next edge
        e = exp_tab[c][got];
        check_instr(case_name[c], e.instr, instr);
        check_pc(case_name[c], e.pc, pc_out);
        check_flag(case_name[c], "comp", e.comp, comp);
        check_flag(case_name[c], "br", e.br, br);
        check_flag(case_name[c], "illegal", e.ill, illegal);
        got++;
      end else if (!instr_valid) begin
        check_instr(case_name[c], fetch_pkg::nop_instr, instr);  // bubble carries a nop
      end
      @(posedge clk);
      #1;
      waited++;
      if (upd_step[c] >= 0 && !upd_done && got == upd_step[c]) begin
        pc_update = 1'b1;
        pc_in = upd_pc[c];
        stall = 1'b0;
        upd_done = 1;
      end else begin
        pc_update = 1'b0;
        stall = ($urandom % 100) < stall_pct[c];
      end
    end
    pc_update = 1'b0;
    stall = 1'b0;
    if (got < exp_n[c]) begin
      $display("%s: only %0d of %0d instructions arrived", case_name[c], got, exp_n[c]);
      other_errs++;
    end
  endtask

  initial begin
    int total;
    rst_n = 1'b0;
    stall = 1'b0;
    pc_update = 1'b0;
    pc_in = '0;
    void'($urandom(32'h28b316ec));
    build_table();
    total = 0;
    for (int c = 0; c < n_cases; c++) total += exp_n[c];
    limit = total * 40 + 200;
    repeat (3) @(posedge clk);
    #1;
    check_instr("reset", fetch_pkg::nop_instr, instr);
    check_flag("reset", "instr_valid", 1'b0, instr_valid);
    check_flag("reset", "arvalid", 1'b0, arvalid);
    rst_n = 1'b1;
    for (int c = 0; c < n_cases; c++) run_case(c);
    $display("errors: %0d mismatches, %0d other failures", mism_errs, other_errs);
    if (mism_errs + other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : fetch_tb

// File: project.f
verilog/fetch_pkg.sv
verilog/fetch_predecode.sv
verilog/fetch_axi_ctrl.sv
verilog/fetch_aligner.sv
verilog/fetch_unit_top.sv
sim/axi_mem_model.sv
sim/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch unit simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module fetch_tb -o fetch_sim \
  > build.log 2>&1 \
  && ./obj_dir/fetch_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
